/* sim.f */
arcade_pkg.sv
cfg_bus_if.sv
apb_cfg_regs.sv
video_stage.sv
sigma_delta_dac.sv
arcade_shell.sv
tb_arcade_shell.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the shell testbench with Verilator, runs it and decides pass or fail from the log.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
	-f sim.f \
	--top-module tb_arcade_shell \
	--Mdir obj_dir \
	-o tb_arcade_shell > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_arcade_shell > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
exit 0

/* tb_arcade_shell.sv */
// Self-checking testbench for the arcade shell; run it as the simulation top over the shell RTL.
`timescale 1ns/1ns
`default_nettype none

module tb_arcade_shell import arcade_pkg::*; ();

	localparam int clk_period = 10;
	localparam int n_reg_trials = 16;
	localparam int n_err_trials = 6;
	localparam int n_rst_trials = 16;
	localparam int n_vid_cycles = 300;
	localparam int n_frames = 2;
	localparam int lines_per_frame = 5;
	localparam int line_len = 16;
	localparam int active_len = 12;
	localparam int n_audio = 4;
	localparam int audio_period = 2 ** audio_w;

	// every APB transfer takes at most three clock cycles.
	localparam int apb_ops = 2 + 2 * n_reg_trials + 6 * n_err_trials + n_rst_trials + 9;
	localparam int frame_cycles = 2 + lines_per_frame * line_len;
	localparam int run_cycles = 8 + 3 * apb_ops + n_rst_trials + n_vid_cycles
		+ 8 * (n_frames * frame_cycles + 2) + n_audio * (2 * audio_period + 1) + 4;
	localparam int watchdog_cycles = 2 * run_cycles + 100;

	logic                  clk_sys;
	logic                  rst_n;
	logic [apb_addr_w-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic [vid_w-1:0]      vid;
	logic                  hblank;
	logic                  vblank;
	logic                  hsync;
	logic                  vsync;
	logic [audio_w-1:0]    audio_l_in;
	logic [audio_w-1:0]    audio_r_in;
	logic                  button_reset;
	logic [rgb_w-1:0]      vga_r;
	logic [rgb_w-1:0]      vga_g;
	logic [rgb_w-1:0]      vga_b;
	logic                  vga_hs;
	logic                  vga_vs;
	logic                  audio_l;
	logic                  audio_r;
	logic                  core_reset_n;
	logic                  test_n;

	logic [31:0] lcg_state;
	int          errors;
	int          checks;

	// video model state that mirrors what the shell should hold after each edge.
	int          m_prev;
	logic        m_hs_q;
	logic        m_odd;
	int          exp_grey;
	logic        exp_hs;
	logic        exp_vs;
	scan_mode_e  cur_scan;
	logic        cur_blend;

	arcade_shell DUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.vid          (vid),
		.hblank       (hblank),
		.vblank       (vblank),
		.hsync        (hsync),
		.vsync        (vsync),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.button_reset (button_reset),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.core_reset_n (core_reset_n),
		.test_n       (test_n)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic apb_write(input logic [apb_addr_w-1:0] addr,
		input logic [apb_data_w-1:0] data, output logic err);
		@(posedge clk_sys);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		#3;
		err = pslverr;
		check(32'(pready), 32'd1, "pready during write");
		@(posedge clk_sys);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [apb_addr_w-1:0] addr,
		output logic [apb_data_w-1:0] data, output logic err);
		@(posedge clk_sys);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		#3;
		data = prdata;
		err = pslverr;
		check(32'(pready), 32'd1, "pready during read");
		@(posedge clk_sys);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// expected grey level on all three guns for one pixel.
	function automatic int model_grey(input int v, input int prev, input logic odd,
		input logic bl, input scan_mode_e scan, input logic blank);
		int p;
		p = bl ? (v + prev) / 2 : v;
		if (odd) begin
			case (scan)
				scan_25: p = p - p / 4;
				scan_50: p = p / 2;
				scan_75: p = p / 4;
				default: begin
				end
			endcase
		end
		if (blank) begin
			return 0;
		end
		return p / (2 ** (vid_w - rgb_w));
	endfunction

	// checks the outputs of the last pixel, then drives the next one.
	task automatic video_cycle(input int v, input logic hb, input logic vb,
		input logic hs, input logic vs);
		@(posedge clk_sys);
		#1;
		check(32'(vga_r), 32'(exp_grey), "vga_r");
		check(32'(vga_g), 32'(exp_grey), "vga_g");
		check(32'(vga_b), 32'(exp_grey), "vga_b");
		check(32'(vga_hs), 32'(exp_hs), "vga_hs");
		check(32'(vga_vs), 32'(exp_vs), "vga_vs");
		exp_grey = model_grey(v, m_prev, m_odd, cur_blend, cur_scan, hb | vb);
		exp_hs = hs;
		exp_vs = vs;
		if (vs) begin
			m_odd = 1'b0;
		end else if (hs && !m_hs_q) begin
			m_odd = ~m_odd;
		end
		m_prev = v;
		m_hs_q = hs;
		vid = 8'(v);
		hblank = hb;
		vblank = vb;
		hsync = hs;
		vsync = vs;
	endtask

	task automatic video_frame();
		logic [31:0] r;
		for (int c = 0; c < 2; c++) begin
			r = next_rand();
			video_cycle(int'(r[31:24]), 1'b1, 1'b1, 1'b0, 1'b1);
		end
		for (int ln = 0; ln < lines_per_frame; ln++) begin
			for (int px = 0; px < line_len; px++) begin
				r = next_rand();
				video_cycle(int'(r[31:24]), px >= active_len, 1'b0,
					px == active_len + 1 || px == active_len + 2, 1'b0);
			end
		end
		video_cycle(0, 1'b0, 1'b0, 1'b0, 1'b0);
		video_cycle(0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic audio_trial();
		logic [31:0]        r;
		logic [audio_w-1:0] sl;
		logic [audio_w-1:0] sr;
		int                 cnt_l;
		int                 cnt_r;
		r = next_rand();
		sl = r[31:25];
		sr = r[24:18];
		cnt_l = 0;
		cnt_r = 0;
		@(posedge clk_sys);
		#1;
		audio_l_in = sl;
		audio_r_in = sr;
		repeat (audio_period) @(posedge clk_sys);
		for (int k = 0; k < audio_period; k++) begin
			@(posedge clk_sys);
			#1;
			if (audio_l) begin
				cnt_l++;
			end
			if (audio_r) begin
				cnt_r++;
			end
		end
		check(32'(cnt_l), 32'(sl), "left pin density");
		check(32'(cnt_r), 32'(sr), "right pin density");
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: the testbench did not reach its end in time");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0]           r;
		logic [apb_data_w-1:0] rd;
		logic [apb_data_w-1:0] ctrl_model;
		logic [apb_addr_w-1:0] bad;
		logic                  err;
		logic [apb_data_w-1:0] cfg_word;
		lcg_state = 32'hd05e767e;
		errors = 0;
		checks = 0;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		vid = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		audio_l_in = '0;
		audio_r_in = '0;
		button_reset = 1'b0;
		m_prev = 0;
		m_hs_q = 1'b0;
		m_odd = 1'b0;
		exp_grey = 0;
		exp_hs = 1'b0;
		exp_vs = 1'b0;
		cur_scan = scan_off;
		cur_blend = 1'b0;
		ctrl_model = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		// right after reset only the button holds the core.
		#3;
		check(32'(core_reset_n), 32'd1, "core_reset_n after reset");
		check(32'(test_n), 32'd1, "test_n after reset");
		button_reset = 1'b1;
		#1;
		check(32'(core_reset_n), 32'd0, "core_reset_n with button");
		button_reset = 1'b0;

		apb_read(reg_ctrl_addr, rd, err);
		check(rd, 32'd0, "control after reset");
		check(32'(err), 32'd0, "pslverr on control read");
		apb_read(reg_id_addr, rd, err);
		check(rd, build_id, "build identifier");
		check(32'(err), 32'd0, "pslverr on identifier read");
		for (int i = 0; i < n_reg_trials; i++) begin
			r = next_rand();
			apb_write(reg_ctrl_addr, r, err);
			check(32'(err), 32'd0, "pslverr on control write");
			ctrl_model = r & ctrl_mask;
			apb_read(reg_ctrl_addr, rd, err);
			check(rd, ctrl_model, "control readback");
		end
		for (int i = 0; i < n_err_trials; i++) begin
			r = next_rand();
			apb_write(reg_id_addr, r, err);
			check(32'(err), 32'd1, "pslverr on identifier write");
			apb_read(reg_id_addr, rd, err);
			check(rd, build_id, "identifier after write");
			apb_read(reg_ctrl_addr, rd, err);
			check(rd, ctrl_model, "control after identifier write");
			bad = r[31:24];
			if (bad == reg_ctrl_addr || bad == reg_id_addr) begin
				bad = bad | 8'h80;
			end
			apb_write(bad, next_rand(), err);
			check(32'(err), 32'd1, "pslverr on unmapped write");
			apb_read(bad, rd, err);
			check(32'(err), 32'd1, "pslverr on unmapped read");
			apb_read(reg_ctrl_addr, rd, err);
			check(rd, ctrl_model, "control after unmapped access");
		end

		for (int i = 0; i < n_rst_trials; i++) begin
			r = next_rand();
			apb_write(reg_ctrl_addr, r, err);
			button_reset = r[31];
			#3;
			check(32'(core_reset_n), 32'(!(r[ctrl_reset_bit] | r[31])), "core_reset_n");
			check(32'(test_n), 32'(!r[ctrl_test_bit]), "test_n");
		end
		button_reset = 1'b0;

		apb_write(reg_ctrl_addr, 32'd0, err);
		for (int i = 0; i < n_vid_cycles; i++) begin
			r = next_rand();
			video_cycle(int'(r[31:24]), r[23] & r[22], r[21] & r[20], r[19],
				r[18] & r[17]);
		end
		video_cycle(0, 1'b0, 1'b0, 1'b0, 1'b0);
		video_cycle(0, 1'b0, 1'b0, 1'b0, 1'b0);

		for (int s = 0; s < 4; s++) begin
			for (int b = 0; b < 2; b++) begin
				cfg_word = '0;
				cfg_word[ctrl_scan_lsb +: 2] = 2'(s);
				cfg_word[ctrl_blend_bit] = (b == 1);
				apb_write(reg_ctrl_addr, cfg_word, err);
				cur_scan = scan_mode_e'(s);
				cur_blend = (b == 1);
				for (int f = 0; f < n_frames; f++) begin
					video_frame();
				end
			end
		end

		for (int t = 0; t < n_audio; t++) begin
			audio_trial();
		end

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* arcade_shell.sv */
// Top of the platform shell: APB option registers, video stage and two audio converters around the game core.
`timescale 1ns/1ns
`default_nettype none

module arcade_shell import arcade_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	// host register access.
	input  logic [apb_addr_w-1:0] paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,

	// video and audio from the core.
	input  logic [vid_w-1:0]      vid,
	input  logic                  hblank,
	input  logic                  vblank,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic [audio_w-1:0]    audio_l_in,
	input  logic [audio_w-1:0]    audio_r_in,

	input  logic                  button_reset,

	// board pins.
	output logic [rgb_w-1:0]      vga_r,
	output logic [rgb_w-1:0]      vga_g,
	output logic [rgb_w-1:0]      vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  audio_l,
	output logic                  audio_r,

	// back to the core.
	output logic                  core_reset_n,
	output logic                  test_n
);

	cfg_bus_if cfg ();

	apb_cfg_regs regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cfg     (cfg.regs)
	);

	video_stage video (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.vid     (vid),
		.hblank  (hblank),
		.vblank  (vblank),
		.hsync   (hsync),
		.vsync   (vsync),
		.cfg     (cfg.video),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	sigma_delta_dac #(.width(audio_w)) dac_l (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio_l_in),
		.dac     (audio_l)
	);

	sigma_delta_dac #(.width(audio_w)) dac_r (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio_r_in),
		.dac     (audio_r)
	);

	// the core is held in reset by either the host bit or the board button.
	assign core_reset_n = ~(cfg.soft_reset | button_reset);
	assign test_n = ~cfg.self_test;

endmodule

`default_nettype wire

/* sigma_delta_dac.sv */
// First-order sigma-delta converter that turns a parallel audio sample into a one-bit pin stream.
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac import arcade_pkg::*; #(
	parameter int width = audio_w
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [width-1:0] sample,
	output logic             dac
);

	// the top bit holds the carry of the last addition.
	logic [width:0] acc;

	// the carry is dropped before each add, so only the residue accumulates.
	// Over 2**width cycles this gives exactly sample carries.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[width-1:0]} + {1'b0, sample};
		end
	end

	// pin is the registered carry.
	assign dac = acc[width];

endmodule

`default_nettype wire

/* video_stage.sv */
// Video path of the shell: pixel blend, scanline darkening, blanking and grey to RGB, one cycle latency.
`timescale 1ns/1ns
`default_nettype none

module video_stage import arcade_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [vid_w-1:0] vid,
	input  logic             hblank,
	input  logic             vblank,
	input  logic             hsync,
	input  logic             vsync,
	cfg_bus_if.video         cfg,
	output logic [rgb_w-1:0] vga_r,
	output logic [rgb_w-1:0] vga_g,
	output logic [rgb_w-1:0] vga_b,
	output logic             vga_hs,
	output logic             vga_vs
);

	logic [vid_w-1:0] prev_vid;
	logic             hsync_q;
	logic             line_odd;
	logic             hsync_rise;
	logic [vid_w:0]   pair_sum;
	logic [vid_w-1:0] blended;
	logic [vid_w-1:0] shaded;
	logic [rgb_w-1:0] grey;

	// the extra bit keeps the carry so the average is a true floor.
	assign pair_sum = {1'b0, vid} + {1'b0, prev_vid};
	assign blended = cfg.blend ? pair_sum[vid_w:1] : vid;

	// only odd lines are darkened.
	// Even lines and scan_off pass the blended value through.
	always_comb begin
		shaded = blended;
		if (line_odd) begin
			case (cfg.scan_mode)
				scan_25: begin
					shaded = blended - (blended >> 2);
				end
				scan_50: begin
					shaded = blended >> 1;
				end
				scan_75: begin
					shaded = blended >> 2;
				end
				default: begin
					shaded = blended;
				end
			endcase
		end
	end

	// top bits of the grey level feed all three guns.
	assign grey = (hblank || vblank) ? '0 : shaded[vid_w-1 -: rgb_w];

	assign hsync_rise = hsync & ~hsync_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			prev_vid <= '0;
			hsync_q <= 1'b0;
			line_odd <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			prev_vid <= vid;
			hsync_q <= hsync;

			// the first line after vsync counts as even.
			if (vsync) begin
				line_odd <= 1'b0;
			end else if (hsync_rise) begin
				line_odd <= ~line_odd;
			end

			vga_r <= grey;
			vga_g <= grey;
			vga_b <= grey;
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

endmodule

`default_nettype wire

/* apb_cfg_regs.sv */
// APB slave with the option control register and a read-only build identifier; drives the settings bus.
`timescale 1ns/1ns
`default_nettype none

module apb_cfg_regs import arcade_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	cfg_bus_if.regs               cfg
);

	logic [apb_data_w-1:0] ctrl_q;
	logic                  access;
	logic                  hit_ctrl;
	logic                  hit_id;
	logic                  bad_addr;
	logic                  id_write;
	logic                  ctrl_write;

	// the access phase is the only cycle in which anything is decided.
	assign access = psel & penable;

	assign hit_ctrl = (paddr == reg_ctrl_addr);
	assign hit_id = (paddr == reg_id_addr);
	assign bad_addr = ~(hit_ctrl | hit_id);
	assign id_write = pwrite & hit_id;

	// no wait states.
	assign pready = 1'b1;

	// errors are flagged in the access phase and leave all registers untouched.
	assign pslverr = access & (bad_addr | id_write);

	assign ctrl_write = access & pwrite & hit_ctrl;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else if (ctrl_write) begin
			ctrl_q <= pwdata & ctrl_mask;
		end
	end

	// read data is decoded from the address already in setup.
	// It stays stable through the access phase.
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_ctrl) begin
				prdata = ctrl_q;
			end else if (hit_id) begin
				prdata = build_id;
			end
		end
	end

	assign cfg.soft_reset = ctrl_q[ctrl_reset_bit];
	assign cfg.self_test = ctrl_q[ctrl_test_bit];
	assign cfg.scan_mode = scan_mode_e'(ctrl_q[ctrl_scan_lsb +: 2]);
	assign cfg.blend = ctrl_q[ctrl_blend_bit];

endmodule

`default_nettype wire

/* cfg_bus_if.sv */
// Option settings bus from the APB register block to the video stage and the shell top.
`timescale 1ns/1ns
`default_nettype none

interface cfg_bus_if import arcade_pkg::*; ();

	logic       soft_reset;
	logic       self_test;
	scan_mode_e scan_mode;
	logic       blend;

	// the register block owns every field.
	modport regs (
		output soft_reset,
		output self_test,
		output scan_mode,
		output blend
	);

	// the video path only needs the picture options.
	modport video (
		input scan_mode,
		input blend
	);

endinterface

`default_nettype wire

/* arcade_pkg.sv */
// Shared register map, field positions, widths and scanline modes, imported by the shell RTL and its testbench.
`default_nettype none

package arcade_pkg;

	// apb bus geometry.
	localparam int apb_addr_w = 8;
	localparam int apb_data_w = 32;

	// byte addresses of the two mapped registers.
	localparam logic [apb_addr_w-1:0] reg_ctrl_addr = 8'h00;
	localparam logic [apb_addr_w-1:0] reg_id_addr = 8'h04;

	// control register fields.
	localparam int ctrl_reset_bit = 0;
	localparam int ctrl_test_bit = 1;
	localparam int ctrl_scan_lsb = 3;
	localparam int ctrl_blend_bit = 5;

	// only these bits are stored.
	// Bit 2 and everything above bit 5 read back as zero.
	localparam logic [apb_data_w-1:0] ctrl_mask = 32'h0000_003b;

	// returned by the identifier register so a host can recognise the shell.
	localparam logic [apb_data_w-1:0] build_id = 32'h4152_4331;

	// scanline darkening applied on odd lines.
	typedef enum logic [1:0] {
		scan_off = 2'd0,
		scan_25 = 2'd1,
		scan_50 = 2'd2,
		scan_75 = 2'd3
	} scan_mode_e;

	// the core delivers 8-bit grey, the board takes 6 bits per colour.
	localparam int vid_w = 8;
	localparam int rgb_w = 6;

	// audio samples from the core.
	localparam int audio_w = 7;

endpackage

`default_nettype wire
